// ==== rtl/soc_map_pkg.sv ====
/* Address map, bus widths, register offsets and core id of the uncore */
`default_nettype none

package soc_map_pkg;

  // Bus widths
  localparam int unsigned addr_width = 12;
  localparam int unsigned data_width = 32;

  // Device field of the address, the bits below it are the register offset
  localparam int unsigned dev_field_msb = 11;
  localparam int unsigned dev_field_lsb = 8;

  localparam logic [dev_field_msb-dev_field_lsb:0] dev_cfg_id   = 4'd0;
  localparam logic [dev_field_msb-dev_field_lsb:0] dev_clint_id = 4'd1;

  // Configuration block offsets
  localparam logic [dev_field_lsb-1:0] cfg_core_id_off = 8'h00;
  localparam logic [dev_field_lsb-1:0] cfg_freeze_off  = 8'h04;
  localparam logic [dev_field_lsb-1:0] cfg_scratch_off = 8'h08;

  // CLINT offsets
  localparam logic [dev_field_lsb-1:0] clint_msip_off     = 8'h00;
  localparam logic [dev_field_lsb-1:0] clint_mtimecmp_off = 8'h08;
  localparam logic [dev_field_lsb-1:0] clint_mtime_off    = 8'h10;

  // Value returned by the read-only core id register
  localparam logic [data_width-1:0] core_id_value = 32'h0000_0005;

endpackage

`default_nettype wire

// ==== rtl/soc_bus_pkg.sv ====
/* Device bus enums: operation, device select, arbiter state, requester */
`default_nettype none

package soc_bus_pkg;

  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } bus_op_e;

  typedef enum logic [1:0]
  {
    sel_cfg   = 2'd0,
    sel_clint = 2'd1,
    sel_none  = 2'd2
  } dev_sel_e;

  typedef enum logic
  {
    arb_idle = 1'b0,
    arb_busy = 1'b1
  } arb_state_e;

  // Requester that holds the bus
  typedef enum logic
  {
    src_core = 1'b0,
    src_io   = 1'b1
  } req_src_e;

endpackage

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
/* Round-robin arbiter of the core and I/O requesters onto the device bus,
   with response return to the granted port */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
  (input  logic                               clk_i
   , input  logic                             rst_n_i

   , input  logic                             core_req_v_i
   , input  logic                             core_req_we_i
   , input  logic [soc_map_pkg::addr_width-1:0] core_req_addr_i
   , input  logic [soc_map_pkg::data_width-1:0] core_req_wdata_i
   , output logic                             core_req_ready_o
   , output logic                             core_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0] core_rsp_rdata_o
   , output logic                             core_rsp_err_o

   , input  logic                             io_req_v_i
   , input  logic                             io_req_we_i
   , input  logic [soc_map_pkg::addr_width-1:0] io_req_addr_i
   , input  logic [soc_map_pkg::data_width-1:0] io_req_wdata_i
   , output logic                             io_req_ready_o
   , output logic                             io_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0] io_rsp_rdata_o
   , output logic                             io_rsp_err_o

   , output logic                             bus_v_o
   , output soc_bus_pkg::bus_op_e             bus_op_o
   , output logic [soc_map_pkg::addr_width-1:0] bus_addr_o
   , output logic [soc_map_pkg::data_width-1:0] bus_wdata_o
   , input  logic                             bus_rsp_v_i
   , input  logic [soc_map_pkg::data_width-1:0] bus_rdata_i
   , input  logic                             bus_err_i
   );

  soc_bus_pkg::arb_state_e state_q;
  soc_bus_pkg::req_src_e last_src_q;
  logic bus_v_q;
  soc_bus_pkg::bus_op_e bus_op_q;
  logic [soc_map_pkg::addr_width-1:0] bus_addr_q;
  logic [soc_map_pkg::data_width-1:0] bus_wdata_q;
  logic idle;
  logic core_accept;
  logic io_accept;

  assign idle = (state_q == soc_bus_pkg::arb_idle);

  // A port yields only when the other one requests and has priority
  assign core_req_ready_o = idle & ~(io_req_v_i & (last_src_q == soc_bus_pkg::src_core));
  assign io_req_ready_o   = idle & ~(core_req_v_i & (last_src_q == soc_bus_pkg::src_io));

  assign core_accept = core_req_v_i & core_req_ready_o;
  assign io_accept   = io_req_v_i & io_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= soc_bus_pkg::arb_idle;
      last_src_q <= soc_bus_pkg::src_io;
      bus_v_q    <= 1'b0;
    end
    else
    begin
      bus_v_q <= core_accept | io_accept;
      if (core_accept)
      begin
        state_q    <= soc_bus_pkg::arb_busy;
        last_src_q <= soc_bus_pkg::src_core;
      end
      else if (io_accept)
      begin
        state_q    <= soc_bus_pkg::arb_busy;
        last_src_q <= soc_bus_pkg::src_io;
      end
      else if (bus_rsp_v_i)
        state_q <= soc_bus_pkg::arb_idle;
    end
  end

  // Granted request, captured at acceptance
  always_ff @(posedge clk_i)
  begin
    if (core_accept)
    begin
      bus_op_q    <= soc_bus_pkg::bus_op_e'(core_req_we_i);
      bus_addr_q  <= core_req_addr_i;
      bus_wdata_q <= core_req_wdata_i;
    end
    else if (io_accept)
    begin
      bus_op_q    <= soc_bus_pkg::bus_op_e'(io_req_we_i);
      bus_addr_q  <= io_req_addr_i;
      bus_wdata_q <= io_req_wdata_i;
    end
  end

  assign bus_v_o     = bus_v_q;
  assign bus_op_o    = bus_op_q;
  assign bus_addr_o  = bus_addr_q;
  assign bus_wdata_o = bus_wdata_q;

  // Response goes back to whoever holds the grant
  assign core_rsp_v_o     = bus_rsp_v_i & (last_src_q == soc_bus_pkg::src_core);
  assign io_rsp_v_o       = bus_rsp_v_i & (last_src_q == soc_bus_pkg::src_io);
  assign core_rsp_rdata_o = bus_rdata_i;
  assign io_rsp_rdata_o   = bus_rdata_i;
  assign core_rsp_err_o   = bus_err_i;
  assign io_rsp_err_o     = bus_err_i;

endmodule

`default_nettype wire

// ==== rtl/dev_decode.sv ====
/* Device bus address decode, response mux and error response for unmapped
   addresses */
`timescale 1ns/1ps
`default_nettype none

module dev_decode
  (input  logic                                  clk_i
   , input  logic                                rst_n_i

   , input  logic                                bus_v_i
   , input  soc_bus_pkg::bus_op_e                bus_op_i
   , input  logic [soc_map_pkg::addr_width-1:0]    bus_addr_i
   , input  logic [soc_map_pkg::data_width-1:0]    bus_wdata_i

   , output logic                                cfg_v_o
   , output logic                                clint_v_o
   , output soc_bus_pkg::bus_op_e                dev_op_o
   , output logic [soc_map_pkg::dev_field_lsb-1:0] dev_off_o
   , output logic [soc_map_pkg::data_width-1:0]    dev_wdata_o

   , input  logic                                cfg_rsp_v_i
   , input  logic [soc_map_pkg::data_width-1:0]    cfg_rdata_i
   , input  logic                                clint_rsp_v_i
   , input  logic [soc_map_pkg::data_width-1:0]    clint_rdata_i

   , output logic                                bus_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0]    bus_rdata_o
   , output logic                                bus_err_o
   );

  logic [soc_map_pkg::dev_field_msb-soc_map_pkg::dev_field_lsb:0] dev_field;
  soc_bus_pkg::dev_sel_e dev_sel;
  logic err_v_q;

  assign dev_field = bus_addr_i[soc_map_pkg::dev_field_msb:soc_map_pkg::dev_field_lsb];

  always_comb
  begin
    if (dev_field == soc_map_pkg::dev_cfg_id)
      dev_sel = soc_bus_pkg::sel_cfg;
    else if (dev_field == soc_map_pkg::dev_clint_id)
      dev_sel = soc_bus_pkg::sel_clint;
    else
      dev_sel = soc_bus_pkg::sel_none;
  end

  assign cfg_v_o     = bus_v_i & (dev_sel == soc_bus_pkg::sel_cfg);
  assign clint_v_o   = bus_v_i & (dev_sel == soc_bus_pkg::sel_clint);
  assign dev_op_o    = bus_op_i;
  assign dev_off_o   = bus_addr_i[soc_map_pkg::dev_field_lsb-1:0];
  assign dev_wdata_o = bus_wdata_i;

  // Unmapped access answers one cycle later, like a real device would
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      err_v_q <= 1'b0;
    else
      err_v_q <= bus_v_i & (dev_sel == soc_bus_pkg::sel_none);
  end

  assign bus_rsp_v_o = cfg_rsp_v_i | clint_rsp_v_i | err_v_q;
  assign bus_err_o   = err_v_q;

  always_comb
  begin
    if (cfg_rsp_v_i)
      bus_rdata_o = cfg_rdata_i;
    else if (clint_rsp_v_i)
      bus_rdata_o = clint_rdata_i;
    else
      bus_rdata_o = '0;
  end

endmodule

`default_nettype wire

// ==== rtl/cfg_regs.sv ====
/* Configuration registers: read-only core id, freeze control, scratch */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  (input  logic                                  clk_i
   , input  logic                                rst_n_i
   , input  logic                                cfg_v_i
   , input  soc_bus_pkg::bus_op_e                dev_op_i
   , input  logic [soc_map_pkg::dev_field_lsb-1:0] dev_off_i
   , input  logic [soc_map_pkg::data_width-1:0]    dev_wdata_i
   , output logic                                cfg_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0]    cfg_rdata_o
   , output logic                                freeze_o
   );

  logic freeze_q;
  logic [soc_map_pkg::data_width-1:0] scratch_q;
  logic [soc_map_pkg::data_width-1:0] read_data;
  logic [soc_map_pkg::data_width-1:0] rdata_q;
  logic rsp_v_q;
  logic wr_en;

  assign wr_en = cfg_v_i & (dev_op_i == soc_bus_pkg::op_write);

  always_comb
  begin
    case (dev_off_i)
      soc_map_pkg::cfg_core_id_off: read_data = soc_map_pkg::core_id_value;
      soc_map_pkg::cfg_freeze_off:  read_data = {{(soc_map_pkg::data_width-1){1'b0}}, freeze_q};
      soc_map_pkg::cfg_scratch_off: read_data = scratch_q;
      default:                      read_data = '0;
    endcase
  end

  // Core stays frozen until software clears bit 0
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_q  <= 1'b1;
      scratch_q <= '0;
      rsp_v_q   <= 1'b0;
    end
    else
    begin
      rsp_v_q <= cfg_v_i;
      if (wr_en && (dev_off_i == soc_map_pkg::cfg_freeze_off))
        freeze_q <= dev_wdata_i[0];
      if (wr_en && (dev_off_i == soc_map_pkg::cfg_scratch_off))
        scratch_q <= dev_wdata_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (cfg_v_i)
      rdata_q <= wr_en ? '0 : read_data;
  end

  assign cfg_rsp_v_o = rsp_v_q;
  assign cfg_rdata_o = rdata_q;
  assign freeze_o    = freeze_q;

endmodule

`default_nettype wire

// ==== rtl/clint_timer.sv ====
/* CLINT: machine time counter, compare register, software interrupt bit and
   the timer and software interrupt lines */
`timescale 1ns/1ps
`default_nettype none

module clint_timer
  (input  logic                                  clk_i
   , input  logic                                rst_n_i
   , input  logic                                clint_v_i
   , input  soc_bus_pkg::bus_op_e                dev_op_i
   , input  logic [soc_map_pkg::dev_field_lsb-1:0] dev_off_i
   , input  logic [soc_map_pkg::data_width-1:0]    dev_wdata_i
   , output logic                                clint_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0]    clint_rdata_o
   , output logic                                timer_irq_o
   , output logic                                software_irq_o
   );

  logic [soc_map_pkg::data_width-1:0] mtime_q;
  logic [soc_map_pkg::data_width-1:0] mtimecmp_q;
  logic msip_q;
  logic timer_irq_q;
  logic rsp_v_q;
  logic [soc_map_pkg::data_width-1:0] rdata_q;
  logic [soc_map_pkg::data_width-1:0] read_data;
  logic wr_en;

  assign wr_en = clint_v_i & (dev_op_i == soc_bus_pkg::op_write);

  always_comb
  begin
    case (dev_off_i)
      soc_map_pkg::clint_msip_off:     read_data = {{(soc_map_pkg::data_width-1){1'b0}}, msip_q};
      soc_map_pkg::clint_mtimecmp_off: read_data = mtimecmp_q;
      soc_map_pkg::clint_mtime_off:    read_data = mtime_q;
      default:                         read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
      rsp_v_q     <= 1'b0;
    end
    else
    begin
      rsp_v_q     <= clint_v_i;
      timer_irq_q <= (mtime_q >= mtimecmp_q);

      // A software write to mtime wins over the increment
      if (wr_en && (dev_off_i == soc_map_pkg::clint_mtime_off))
        mtime_q <= dev_wdata_i;
      else
        mtime_q <= mtime_q + 1;

      if (wr_en && (dev_off_i == soc_map_pkg::clint_mtimecmp_off))
        mtimecmp_q <= dev_wdata_i;
      if (wr_en && (dev_off_i == soc_map_pkg::clint_msip_off))
        msip_q <= dev_wdata_i[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (clint_v_i)
      rdata_q <= wr_en ? '0 : read_data;
  end

  assign clint_rsp_v_o  = rsp_v_q;
  assign clint_rdata_o  = rdata_q;
  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = msip_q;

endmodule

`default_nettype wire

// ==== rtl/uncore_top.sv ====
/* Uncore top: arbiter, address decoder, configuration block and CLINT */
`timescale 1ns/1ps
`default_nettype none

module uncore_top
  (input  logic                               clk_i
   , input  logic                             rst_n_i

   , input  logic                             core_req_v_i
   , input  logic                             core_req_we_i
   , input  logic [soc_map_pkg::addr_width-1:0] core_req_addr_i
   , input  logic [soc_map_pkg::data_width-1:0] core_req_wdata_i
   , output logic                             core_req_ready_o
   , output logic                             core_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0] core_rsp_rdata_o
   , output logic                             core_rsp_err_o

   , input  logic                             io_req_v_i
   , input  logic                             io_req_we_i
   , input  logic [soc_map_pkg::addr_width-1:0] io_req_addr_i
   , input  logic [soc_map_pkg::data_width-1:0] io_req_wdata_i
   , output logic                             io_req_ready_o
   , output logic                             io_rsp_v_o
   , output logic [soc_map_pkg::data_width-1:0] io_rsp_rdata_o
   , output logic                             io_rsp_err_o

   , output logic                             freeze_o
   , output logic                             timer_irq_o
   , output logic                             software_irq_o
   );

  // Shared device bus
  logic bus_v, bus_rsp_v, bus_err;
  soc_bus_pkg::bus_op_e bus_op;
  logic [soc_map_pkg::addr_width-1:0] bus_addr;
  logic [soc_map_pkg::data_width-1:0] bus_wdata, bus_rdata;

  // Per-device side of the decoder
  logic cfg_v, clint_v, cfg_rsp_v, clint_rsp_v;
  soc_bus_pkg::bus_op_e dev_op;
  logic [soc_map_pkg::dev_field_lsb-1:0] dev_off;
  logic [soc_map_pkg::data_width-1:0] dev_wdata, cfg_rdata, clint_rdata;

  bus_arbiter arbiter
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.core_req_v_i(core_req_v_i)
     ,.core_req_we_i(core_req_we_i)
     ,.core_req_addr_i(core_req_addr_i)
     ,.core_req_wdata_i(core_req_wdata_i)
     ,.core_req_ready_o(core_req_ready_o)
     ,.core_rsp_v_o(core_rsp_v_o)
     ,.core_rsp_rdata_o(core_rsp_rdata_o)
     ,.core_rsp_err_o(core_rsp_err_o)
     ,.io_req_v_i(io_req_v_i)
     ,.io_req_we_i(io_req_we_i)
     ,.io_req_addr_i(io_req_addr_i)
     ,.io_req_wdata_i(io_req_wdata_i)
     ,.io_req_ready_o(io_req_ready_o)
     ,.io_rsp_v_o(io_rsp_v_o)
     ,.io_rsp_rdata_o(io_rsp_rdata_o)
     ,.io_rsp_err_o(io_rsp_err_o)
     ,.bus_v_o(bus_v)
     ,.bus_op_o(bus_op)
     ,.bus_addr_o(bus_addr)
     ,.bus_wdata_o(bus_wdata)
     ,.bus_rsp_v_i(bus_rsp_v)
     ,.bus_rdata_i(bus_rdata)
     ,.bus_err_i(bus_err)
     );

  dev_decode decode
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.bus_v_i(bus_v)
     ,.bus_op_i(bus_op)
     ,.bus_addr_i(bus_addr)
     ,.bus_wdata_i(bus_wdata)
     ,.cfg_v_o(cfg_v)
     ,.clint_v_o(clint_v)
     ,.dev_op_o(dev_op)
     ,.dev_off_o(dev_off)
     ,.dev_wdata_o(dev_wdata)
     ,.cfg_rsp_v_i(cfg_rsp_v)
     ,.cfg_rdata_i(cfg_rdata)
     ,.clint_rsp_v_i(clint_rsp_v)
     ,.clint_rdata_i(clint_rdata)
     ,.bus_rsp_v_o(bus_rsp_v)
     ,.bus_rdata_o(bus_rdata)
     ,.bus_err_o(bus_err)
     );

  cfg_regs cfg
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cfg_v_i(cfg_v)
     ,.dev_op_i(dev_op)
     ,.dev_off_i(dev_off)
     ,.dev_wdata_i(dev_wdata)
     ,.cfg_rsp_v_o(cfg_rsp_v)
     ,.cfg_rdata_o(cfg_rdata)
     ,.freeze_o(freeze_o)
     );

  clint_timer clint
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.clint_v_i(clint_v)
     ,.dev_op_i(dev_op)
     ,.dev_off_i(dev_off)
     ,.dev_wdata_i(dev_wdata)
     ,.clint_rsp_v_o(clint_rsp_v)
     ,.clint_rdata_o(clint_rdata)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

endmodule

`default_nettype wire

// ==== sim/uncore_assert.sv ====
/* Arbiter assertions: no ready while busy, one response per bus request,
   fixed response latency */
`timescale 1ns/1ps
`default_nettype none

module uncore_assert
  (input  logic                    clk_i
   , input  logic                  rst_n_i
   , input  logic                  core_req_ready_o
   , input  logic                  io_req_ready_o
   , input  logic                  core_accept
   , input  logic                  io_accept
   , input  logic                  bus_v_o
   , input  logic                  bus_rsp_v_i
   );

  no_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (core_accept || io_accept) |=>
      !(core_req_ready_o || io_req_ready_o) ##1 !(core_req_ready_o || io_req_ready_o))
    else $error("Ready raised while the arbiter is busy");

  one_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_v_o |=> bus_rsp_v_i ##1 !bus_rsp_v_i)
    else $error("Bus request did not get exactly one response");

  rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (core_accept || io_accept) |-> ##2 bus_rsp_v_i)
    else $error("Response missing two cycles after acceptance");

endmodule

bind bus_arbiter uncore_assert arb_checks
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.core_req_ready_o(core_req_ready_o)
   ,.io_req_ready_o(io_req_ready_o)
   ,.core_accept(core_accept)
   ,.io_accept(io_accept)
   ,.bus_v_o(bus_v_o)
   ,.bus_rsp_v_i(bus_rsp_v_i)
   );

`default_nettype wire

// ==== sim/uncore_tb.sv ====
/* Uncore testbench: clock, reset, stimulus, reference model, response checker
   and timeout */
`timescale 1ns/1ps
`default_nettype none

module uncore_tb;

  localparam int planned_trans  = 50;
  localparam int timeout_cycles = 20 * planned_trans + 2000;

  logic clk_i;
  logic rst_n_i;
  logic core_req_v_i, core_req_we_i, io_req_v_i, io_req_we_i;
  logic [soc_map_pkg::addr_width-1:0] core_req_addr_i, io_req_addr_i;
  logic [soc_map_pkg::data_width-1:0] core_req_wdata_i, io_req_wdata_i;
  logic core_req_ready_o, core_rsp_v_o, core_rsp_err_o;
  logic io_req_ready_o, io_rsp_v_o, io_rsp_err_o;
  logic [soc_map_pkg::data_width-1:0] core_rsp_rdata_o, io_rsp_rdata_o;
  logic freeze_o, timer_irq_o, software_irq_o;

  int seed;
  int errors;
  int checks;
  int cyc;

  // Model of the register state
  logic m_freeze;
  logic [31:0] m_scratch;
  logic m_msip;
  logic [31:0] m_mtimecmp;

  // Expected {err, rdata} and acceptance cycle per port, and grant order
  logic [32:0] core_exp_q[$];
  logic [32:0] io_exp_q[$];
  int core_acc_q[$];
  int io_acc_q[$];
  logic grant_q[$];

  uncore_top dut_i
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.core_req_v_i(core_req_v_i)
     ,.core_req_we_i(core_req_we_i)
     ,.core_req_addr_i(core_req_addr_i)
     ,.core_req_wdata_i(core_req_wdata_i)
     ,.core_req_ready_o(core_req_ready_o)
     ,.core_rsp_v_o(core_rsp_v_o)
     ,.core_rsp_rdata_o(core_rsp_rdata_o)
     ,.core_rsp_err_o(core_rsp_err_o)
     ,.io_req_v_i(io_req_v_i)
     ,.io_req_we_i(io_req_we_i)
     ,.io_req_addr_i(io_req_addr_i)
     ,.io_req_wdata_i(io_req_wdata_i)
     ,.io_req_ready_o(io_req_ready_o)
     ,.io_rsp_v_o(io_rsp_v_o)
     ,.io_rsp_rdata_o(io_rsp_rdata_o)
     ,.io_rsp_err_o(io_rsp_err_o)
     ,.freeze_o(freeze_o)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
    checks++;
    if (got !== expv)
    begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, expv);
    end
  endtask

  // Address map rules; returns {err, rdata} and updates the model on writes
  function automatic logic [32:0] ref_access(input logic we, input logic [11:0] addr,
                                             input logic [31:0] wdata);
    logic [3:0] dev;
    logic [7:0] off;
    logic [31:0] rd;
    dev = addr[11:8];
    off = addr[7:0];
    rd = '0;
    if (dev > 4'd1)
      return {1'b1, 32'h0};
    if (we)
    begin
      if (dev == 4'd0 && off == 8'h04)
        m_freeze = wdata[0];
      if (dev == 4'd0 && off == 8'h08)
        m_scratch = wdata;
      if (dev == 4'd1 && off == 8'h00)
        m_msip = wdata[0];
      if (dev == 4'd1 && off == 8'h08)
        m_mtimecmp = wdata;
      return {1'b0, 32'h0};
    end
    if (dev == 4'd0)
    begin
      if (off == 8'h00)
        rd = 32'h5;
      else if (off == 8'h04)
        rd = {31'b0, m_freeze};
      else if (off == 8'h08)
        rd = m_scratch;
    end
    else
    begin
      if (off == 8'h00)
        rd = {31'b0, m_msip};
      else if (off == 8'h08)
        rd = m_mtimecmp;
    end
    return {1'b0, rd};
  endfunction

  function automatic int pending(input logic port);
    if (port)
      return io_exp_q.size();
    return core_exp_q.size();
  endfunction

  // One request on a port; returns once its response has been checked
  task automatic do_req(input logic port, input logic we, input logic [11:0] addr,
                        input logic [31:0] wdata);
    logic accepted;
    @(negedge clk_i);
    if (port)
    begin
      io_req_v_i = 1'b1;
      io_req_we_i = we;
      io_req_addr_i = addr;
      io_req_wdata_i = wdata;
    end
    else
    begin
      core_req_v_i = 1'b1;
      core_req_we_i = we;
      core_req_addr_i = addr;
      core_req_wdata_i = wdata;
    end
    do
    begin
      @(posedge clk_i);
      accepted = port ? io_req_ready_o : core_req_ready_o;
    end
    while (!accepted);
    @(negedge clk_i);
    if (port)
      io_req_v_i = 1'b0;
    else
      core_req_v_i = 1'b0;
    while (pending(port) > 0)
      @(negedge clk_i);
  endtask

  // Back-to-back reads on a port, valid stays high between acceptances
  task automatic stream_reads(input logic port, input int count, input logic [11:0] addr);
    logic accepted;
    @(negedge clk_i);
    if (port)
    begin
      io_req_v_i = 1'b1;
      io_req_we_i = 1'b0;
      io_req_addr_i = addr;
      io_req_wdata_i = '0;
    end
    else
    begin
      core_req_v_i = 1'b1;
      core_req_we_i = 1'b0;
      core_req_addr_i = addr;
      core_req_wdata_i = '0;
    end
    repeat (count)
    begin
      do
      begin
        @(posedge clk_i);
        accepted = port ? io_req_ready_o : core_req_ready_o;
      end
      while (!accepted);
      @(negedge clk_i);
    end
    if (port)
      io_req_v_i = 1'b0;
    else
      core_req_v_i = 1'b0;
    while (pending(port) > 0)
      @(negedge clk_i);
  endtask

  // Compare process
  always @(posedge clk_i)
  begin
    logic [32:0] expv;
    int acc;
    cyc = cyc + 1;
    if (rst_n_i)
    begin
      if (core_rsp_v_o)
      begin
        if (core_exp_q.size() == 0)
        begin
          errors++;
          $display("Response on the core port without a pending request");
        end
        else
        begin
          expv = core_exp_q.pop_front();
          acc = core_acc_q.pop_front();
          check_val("core_rsp_rdata_o", core_rsp_rdata_o, expv[31:0]);
          check_val("core_rsp_err_o", 32'(core_rsp_err_o), 32'(expv[32]));
          check_val("core response latency", 32'(cyc - acc), 32'd2);
        end
      end
      if (io_rsp_v_o)
      begin
        if (io_exp_q.size() == 0)
        begin
          errors++;
          $display("Response on the io port without a pending request");
        end
        else
        begin
          expv = io_exp_q.pop_front();
          acc = io_acc_q.pop_front();
          check_val("io_rsp_rdata_o", io_rsp_rdata_o, expv[31:0]);
          check_val("io_rsp_err_o", 32'(io_rsp_err_o), 32'(expv[32]));
          check_val("io response latency", 32'(cyc - acc), 32'd2);
        end
      end
      if (core_req_v_i && core_req_ready_o)
      begin
        core_exp_q.push_back(ref_access(core_req_we_i, core_req_addr_i, core_req_wdata_i));
        core_acc_q.push_back(cyc);
        grant_q.push_back(1'b0);
      end
      if (io_req_v_i && io_req_ready_o)
      begin
        io_exp_q.push_back(ref_access(io_req_we_i, io_req_addr_i, io_req_wdata_i));
        io_acc_q.push_back(cyc);
        grant_q.push_back(1'b1);
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (cyc >= timeout_cycles)
    begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] rnd;
    logic [11:0] addr;
    int wait_cnt;
    logic stayed;
    seed = 74;
    errors = 0;
    checks = 0;
    cyc = 0;
    m_freeze = 1'b1;
    m_scratch = '0;
    m_msip = 1'b0;
    m_mtimecmp = '1;
    rst_n_i = 1'b0;
    core_req_v_i = 1'b0;
    core_req_we_i = 1'b0;
    core_req_addr_i = '0;
    core_req_wdata_i = '0;
    io_req_v_i = 1'b0;
    io_req_we_i = 1'b0;
    io_req_addr_i = '0;
    io_req_wdata_i = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset values and core id
    @(negedge clk_i);
    check_val("freeze_o", 32'(freeze_o), 32'd1);
    check_val("timer_irq_o", 32'(timer_irq_o), 32'd0);
    check_val("software_irq_o", 32'(software_irq_o), 32'd0);
    check_val("core_req_ready_o", 32'(core_req_ready_o), 32'd1);
    check_val("io_req_ready_o", 32'(io_req_ready_o), 32'd1);
    do_req(1'b0, 1'b0, 12'h000, 32'h0);
    do_req(1'b1, 1'b0, 12'h000, 32'h0);

    // Random scratch and freeze write then read
    repeat (12)
    begin
      rnd = $random(seed);
      addr = rnd[1] ? 12'h008 : 12'h004;
      do_req(rnd[0], 1'b1, addr, $random(seed));
      rnd = $random(seed);
      do_req(rnd[0], 1'b0, addr, 32'h0);
      check_val("freeze_o", 32'(freeze_o), 32'(m_freeze));
    end

    // Unmapped devices
    repeat (4)
    begin
      rnd = $random(seed);
      addr = {4'd2 + {1'b0, rnd[2:0]}, rnd[15:8]};
      do_req(rnd[16], rnd[17], addr, $random(seed));
    end
    do_req(1'b0, 1'b0, 12'h008, 32'h0);
    do_req(1'b1, 1'b0, 12'h004, 32'h0);

    // Both ports at once, io served last so core wins first
    do_req(1'b1, 1'b0, 12'h000, 32'h0);
    grant_q.delete();
    fork
      begin
        stream_reads(1'b0, 4, 12'h008);
      end
      begin
        stream_reads(1'b1, 4, 12'h000);
      end
    join
    check_val("grant count", 32'(grant_q.size()), 32'd8);
    for (int i = 0; i < grant_q.size(); i++)
      check_val("granted port", 32'(grant_q[i]), 32'(i % 2));

    // Software interrupt
    do_req(1'b0, 1'b1, 12'h100, 32'h1);
    check_val("software_irq_o", 32'(software_irq_o), 32'd1);
    do_req(1'b1, 1'b0, 12'h100, 32'h0);
    do_req(1'b0, 1'b1, 12'h100, 32'h0);
    check_val("software_irq_o", 32'(software_irq_o), 32'd0);

    // Timer interrupt
    do_req(1'b0, 1'b1, 12'h110, 32'h0);
    do_req(1'b0, 1'b1, 12'h108, 32'd100);
    check_val("timer_irq_o", 32'(timer_irq_o), 32'd0);
    wait_cnt = 0;
    while (!timer_irq_o && wait_cnt < 110)
    begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!timer_irq_o)
    begin
      errors++;
      $display("Timer interrupt did not rise within 110 cycles");
    end
    stayed = 1'b1;
    repeat (20)
    begin
      @(negedge clk_i);
      if (!timer_irq_o)
        stayed = 1'b0;
    end
    check_val("timer_irq_o held", 32'(stayed), 32'd1);
    do_req(1'b1, 1'b1, 12'h108, 32'hffff_ffff);
    check_val("timer_irq_o", 32'(timer_irq_o), 32'd0);
    do_req(1'b1, 1'b0, 12'h108, 32'h0);

    if (core_exp_q.size() != 0 || io_exp_q.size() != 0)
    begin
      errors++;
      $display("Some accepted requests never got a response");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/soc_map_pkg.sv
rtl/soc_bus_pkg.sv
rtl/bus_arbiter.sv
rtl/dev_decode.sv
rtl/cfg_regs.sv
rtl/clint_timer.sv
rtl/uncore_top.sv
sim/uncore_assert.sv
sim/uncore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the uncore simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uncore_tb -f files.f -o uncore_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/uncore_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

echo "Simulation passed"
exit 0
